// ==== verilog/tcp_cfg_pkg.sv ====
/*
  Stack-wide configuration constants
  Region count and sequence queue depth
  TCP field and network stream widths
  Derived pointer, counter and beat index widths
*/
`default_nettype none

package tcp_cfg_pkg;

  // User regions
  localparam int N_REGIONS      = 4;
  localparam int N_REGIONS_BITS = 2;

  // Outstanding read packages per sequence queue
  localparam int N_OUTSTANDING = 8;
  localparam int SEQ_PTR_BITS  = $clog2(N_OUTSTANDING);
  localparam int SEQ_CNT_BITS  = $clog2(N_OUTSTANDING + 1);

  // TCP fields
  localparam int TCP_SID_BITS = 16;
  localparam int TCP_LEN_BITS = 16;

  // --------------------
  // Network stream
  localparam int AXI_NET_BITS  = 512;
  localparam int AXI_KEEP_BITS = AXI_NET_BITS / 8;
  // 64 bytes per beat
  localparam int BEAT_LOG_BITS = 6;
  // Beat index, one spare bit over len / 64
  localparam int BEAT_CNT_BITS = TCP_LEN_BITS - BEAT_LOG_BITS + 1;

  // Region data FIFO
  localparam int REGION_FIFO_DEPTH = 16;
  localparam int FIFO_PTR_BITS     = $clog2(REGION_FIFO_DEPTH);
  localparam int FIFO_CNT_BITS     = $clog2(REGION_FIFO_DEPTH + 1);

endpackage

`default_nettype wire

// ==== verilog/tcp_rx_pkg.sv ====
/*
  Receive path payload types
  Read-package request toward the TCP engine
  Receive metadata returned by the engine
  Payload beat of the network stream
  Data sequence entry, region and length
*/
`default_nettype none

package tcp_rx_pkg;

  // --------------------
  // Request and metadata

  // Read-package request from a region
  typedef struct packed {
    logic [tcp_cfg_pkg::TCP_SID_BITS-1:0] sid;
    logic [tcp_cfg_pkg::TCP_LEN_BITS-1:0] len;
  } tcp_rd_pkg_t;

  // Receive notification from the engine
  typedef struct packed {
    logic [tcp_cfg_pkg::TCP_SID_BITS-1:0] sid;
    logic [tcp_cfg_pkg::TCP_LEN_BITS-1:0] len;
  } tcp_rx_meta_t;

  // --------------------
  // Payload

  // One beat, last passes through untouched
  typedef struct packed {
    logic [tcp_cfg_pkg::AXI_NET_BITS-1:0]  data;
    logic [tcp_cfg_pkg::AXI_KEEP_BITS-1:0] keep;
    logic                                  last;
  } axis_beat_t;

  // Order record for data steering
  typedef struct packed {
    logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] region;
    logic [tcp_cfg_pkg::TCP_LEN_BITS-1:0]   len;
  } seq_entry_t;

endpackage

`default_nettype wire

// ==== verilog/meta_arbiter.sv ====
/*
  Round-robin arbiter for region requests
  Combinational selection from the request inputs
  Pointer moves past the winner on each transfer
*/
`timescale 1ns/1ps
`default_nettype none

module meta_arbiter (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic                                   req_valid [tcp_cfg_pkg::N_REGIONS],
  output logic                                   req_ready [tcp_cfg_pkg::N_REGIONS],
  input  tcp_rx_pkg::tcp_rd_pkg_t                req_data  [tcp_cfg_pkg::N_REGIONS],
  output logic                                   grant_valid,
  input  logic                                   grant_ready,
  output tcp_rx_pkg::tcp_rd_pkg_t                grant_data,
  output logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] grant_id
);

  // Highest priority region
  logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] rr_ptr;
  logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] sel_id;
  logic                                   found;

  // --------------------
  // Selection
  // First valid region at or after the pointer
  always_comb begin
    int cand;
    found  = 1'b0;
    sel_id = rr_ptr;
    for (int k = 0; k < tcp_cfg_pkg::N_REGIONS; k++) begin
      cand = int'(rr_ptr) + k;
      // Wrap past the last region
      if (cand >= tcp_cfg_pkg::N_REGIONS) begin
        cand = cand - tcp_cfg_pkg::N_REGIONS;
      end
      if (!found && req_valid[cand]) begin
        found  = 1'b1;
        sel_id = cand[tcp_cfg_pkg::N_REGIONS_BITS-1:0];
      end
    end
  end

  assign grant_valid = found;
  assign grant_data  = req_data[sel_id];
  assign grant_id    = sel_id;

  // Only the winner sees ready
  always_comb begin
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin
      req_ready[i] = grant_ready && found && (int'(sel_id) == i);
    end
  end

  // --------------------
  // Pointer
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (grant_valid && grant_ready) begin
      // Winner drops to lowest priority
      if (int'(sel_id) == tcp_cfg_pkg::N_REGIONS - 1) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= sel_id + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/seq_queue.sv ====
/*
  Sequence queue for outstanding requests
  Circular buffer, first-word-fall-through head
  Entry width set per instance
*/
`timescale 1ns/1ps
`default_nettype none

module seq_queue #(
  parameter int ENTRY_BITS = 2
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  logic [ENTRY_BITS-1:0] push_data,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output logic [ENTRY_BITS-1:0] pop_data
);

  logic [ENTRY_BITS-1:0]                mem [tcp_cfg_pkg::N_OUTSTANDING];
  logic [tcp_cfg_pkg::SEQ_PTR_BITS-1:0] wr_ptr;
  logic [tcp_cfg_pkg::SEQ_PTR_BITS-1:0] rd_ptr;
  logic [tcp_cfg_pkg::SEQ_CNT_BITS-1:0] count;
  logic                                 push_fire;
  logic                                 pop_fire;

  // Room and head status from occupancy
  assign push_ready = (int'(count) != tcp_cfg_pkg::N_OUTSTANDING);
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // --------------------
  // Storage
  always_ff @(posedge aclk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and count
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (int'(wr_ptr) == tcp_cfg_pkg::N_OUTSTANDING - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (int'(rd_ptr) == tcp_cfg_pkg::N_OUTSTANDING - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axis_region_fifo.sv ====
/*
  Payload beat FIFO for one region
  Memory of REGION_FIFO_DEPTH beats
  Registered output stage, stable under back-pressure
*/
`timescale 1ns/1ps
`default_nettype none

module axis_region_fifo (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  tcp_rx_pkg::axis_beat_t in_beat,
  output logic                   out_valid,
  input  logic                   out_ready,
  output tcp_rx_pkg::axis_beat_t out_beat
);

  tcp_rx_pkg::axis_beat_t                mem [tcp_cfg_pkg::REGION_FIFO_DEPTH];
  logic [tcp_cfg_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
  logic [tcp_cfg_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
  logic [tcp_cfg_pkg::FIFO_CNT_BITS-1:0] count;
  logic                                  push;
  logic                                  load;

  // Accept while memory has room
  assign in_ready = (int'(count) != tcp_cfg_pkg::REGION_FIFO_DEPTH);
  assign push     = in_valid && in_ready;
  // Refill output stage when empty or draining
  assign load     = (count != '0) && (!out_valid || out_ready);

  // --------------------
  // Memory and output payload
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
    if (load) begin
      out_beat <= mem[rd_ptr];
    end
  end

  // Control
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == tcp_cfg_pkg::REGION_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr <= (int'(rd_ptr) == tcp_cfg_pkg::REGION_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !load) begin
        count <= count + 1'b1;
      end else if (load && !push) begin
        count <= count - 1'b1;
      end
      // Valid holds until the region takes the beat
      if (load) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tcp_rx_arbiter.sv ====
/*
  Receive-side region arbiter
  Round-robin merge of region read-package requests
  Two sequence queues record the grant order
  Metadata steered by the meta queue head
  Payload steered by a beat-counting FSM into region FIFOs
*/
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_arbiter (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     rd_pkg_in_valid   [tcp_cfg_pkg::N_REGIONS],
  output logic                     rd_pkg_in_ready   [tcp_cfg_pkg::N_REGIONS],
  input  tcp_rx_pkg::tcp_rd_pkg_t  rd_pkg_in         [tcp_cfg_pkg::N_REGIONS],
  output logic                     rd_pkg_out_valid,
  input  logic                     rd_pkg_out_ready,
  output tcp_rx_pkg::tcp_rd_pkg_t  rd_pkg_out,
  input  logic                     rx_meta_in_valid,
  output logic                     rx_meta_in_ready,
  input  tcp_rx_pkg::tcp_rx_meta_t rx_meta_in,
  output logic                     rx_meta_out_valid [tcp_cfg_pkg::N_REGIONS],
  input  logic                     rx_meta_out_ready [tcp_cfg_pkg::N_REGIONS],
  output tcp_rx_pkg::tcp_rx_meta_t rx_meta_out       [tcp_cfg_pkg::N_REGIONS],
  input  logic                     axis_rx_in_valid,
  output logic                     axis_rx_in_ready,
  input  tcp_rx_pkg::axis_beat_t   axis_rx_in,
  output logic                     axis_rx_out_valid [tcp_cfg_pkg::N_REGIONS],
  input  logic                     axis_rx_out_ready [tcp_cfg_pkg::N_REGIONS],
  output tcp_rx_pkg::axis_beat_t   axis_rx_out       [tcp_cfg_pkg::N_REGIONS]
);

  typedef enum logic {ST_IDLE, ST_MUX} state_t;

  // Arbiter output
  logic                                   grant_valid;
  logic                                   grant_ready;
  logic                                   grant_fire;
  tcp_rx_pkg::tcp_rd_pkg_t                grant_data;
  logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] grant_id;

  // Data sequence queue
  tcp_rx_pkg::seq_entry_t dq_push_data;
  tcp_rx_pkg::seq_entry_t dq_pop_data;
  logic                   dq_push_ready;
  logic                   dq_pop_valid;
  logic                   dq_pop_ready;

  // Meta sequence queue
  logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] mq_pop_data;
  logic                                   mq_push_ready;
  logic                                   mq_pop_valid;
  logic                                   mq_pop_ready;

  // Steering FSM
  state_t                                 state_q;
  logic [tcp_cfg_pkg::N_REGIONS_BITS-1:0] region_q;
  logic [tcp_cfg_pkg::BEAT_CNT_BITS-1:0]  last_q;
  logic [tcp_cfg_pkg::BEAT_CNT_BITS-1:0]  cnt_q;
  logic [tcp_cfg_pkg::BEAT_CNT_BITS-1:0]  head_whole;
  logic [tcp_cfg_pkg::BEAT_CNT_BITS-1:0]  head_last;
  logic                                   beat_fire;
  logic                                   pkg_done;

  // Region FIFO inputs
  logic fifo_in_valid [tcp_cfg_pkg::N_REGIONS];
  logic fifo_in_ready [tcp_cfg_pkg::N_REGIONS];

  // --------------------
  // Request path
  meta_arbiter inst_meta_arbiter (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .req_valid   (rd_pkg_in_valid),
    .req_ready   (rd_pkg_in_ready),
    .req_data    (rd_pkg_in),
    .grant_valid (grant_valid),
    .grant_ready (grant_ready),
    .grant_data  (grant_data),
    .grant_id    (grant_id)
  );

  // Grant needs the engine and room in both queues
  assign grant_ready      = rd_pkg_out_ready && dq_push_ready && mq_push_ready;
  assign grant_fire       = grant_valid && grant_ready;
  // Hold the request back while a queue is full
  assign rd_pkg_out_valid = grant_valid && dq_push_ready && mq_push_ready;
  assign rd_pkg_out       = grant_data;

  assign dq_push_data.region = grant_id;
  assign dq_push_data.len    = grant_data.len;

  seq_queue #(
    .ENTRY_BITS ($bits(tcp_rx_pkg::seq_entry_t))
  ) inst_data_seq (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (grant_fire),
    .push_ready (dq_push_ready),
    .push_data  (dq_push_data),
    .pop_valid  (dq_pop_valid),
    .pop_ready  (dq_pop_ready),
    .pop_data   (dq_pop_data)
  );

  // Region only, for the metadata return
  seq_queue #(
    .ENTRY_BITS (tcp_cfg_pkg::N_REGIONS_BITS)
  ) inst_meta_seq (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (grant_fire),
    .push_ready (mq_push_ready),
    .push_data  (grant_id),
    .pop_valid  (mq_pop_valid),
    .pop_ready  (mq_pop_ready),
    .pop_data   (mq_pop_data)
  );

  // --------------------
  // Metadata path
  // Zero-cycle steer to the head region
  assign rx_meta_in_ready = mq_pop_valid && rx_meta_out_ready[mq_pop_data];
  assign mq_pop_ready     = rx_meta_in_valid && rx_meta_out_ready[mq_pop_data];

  // --------------------
  // Data path
  // Full beats, then last index is ceil(len / 64) - 1
  assign head_whole =
    {1'b0, dq_pop_data.len[tcp_cfg_pkg::TCP_LEN_BITS-1:tcp_cfg_pkg::BEAT_LOG_BITS]};
  assign head_last  = (|dq_pop_data.len[tcp_cfg_pkg::BEAT_LOG_BITS-1:0]) ?
                      head_whole : head_whole - 1'b1;

  assign axis_rx_in_ready = (state_q == ST_MUX) && fifo_in_ready[region_q];
  assign beat_fire        = axis_rx_in_valid && axis_rx_in_ready;
  // Boundary from recorded length, tlast ignored
  assign pkg_done         = beat_fire && (cnt_q == last_q);
  // Pop when idle or on the closing beat
  assign dq_pop_ready     = (state_q == ST_IDLE) || pkg_done;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q  <= ST_IDLE;
      region_q <= '0;
      last_q   <= '0;
      cnt_q    <= '0;
    end else if (dq_pop_valid && dq_pop_ready) begin
      // Next package, back to back if queued
      state_q  <= ST_MUX;
      region_q <= dq_pop_data.region;
      last_q   <= head_last;
      cnt_q    <= '0;
    end else if (pkg_done) begin
      state_q <= ST_IDLE;
    end else if (beat_fire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // --------------------
  // Per-region outputs
  for (genvar i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin : g_region
    assign rx_meta_out_valid[i] = rx_meta_in_valid && mq_pop_valid && (int'(mq_pop_data) == i);
    assign rx_meta_out[i]       = rx_meta_in;

    // Only the selected region sees the beat
    assign fifo_in_valid[i] = (state_q == ST_MUX) && (int'(region_q) == i) && axis_rx_in_valid;

    axis_region_fifo inst_region_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (fifo_in_valid[i]),
      .in_ready  (fifo_in_ready[i]),
      .in_beat   (axis_rx_in),
      .out_valid (axis_rx_out_valid[i]),
      .out_ready (axis_rx_out_ready[i]),
      .out_beat  (axis_rx_out[i])
    );
  end

endmodule

`default_nettype wire

// ==== verilog/tcp_rx_top.sv ====
/*
  Top level of the receive region arbiter
  Fixed port boundary around tcp_rx_arbiter
*/
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_top (
  input  logic                     aclk,
  input  logic                     aresetn,
  // Region requests toward the engine
  input  logic                     rd_pkg_in_valid   [tcp_cfg_pkg::N_REGIONS],
  output logic                     rd_pkg_in_ready   [tcp_cfg_pkg::N_REGIONS],
  input  tcp_rx_pkg::tcp_rd_pkg_t  rd_pkg_in         [tcp_cfg_pkg::N_REGIONS],
  output logic                     rd_pkg_out_valid,
  input  logic                     rd_pkg_out_ready,
  output tcp_rx_pkg::tcp_rd_pkg_t  rd_pkg_out,
  // Metadata back to the regions
  input  logic                     rx_meta_in_valid,
  output logic                     rx_meta_in_ready,
  input  tcp_rx_pkg::tcp_rx_meta_t rx_meta_in,
  output logic                     rx_meta_out_valid [tcp_cfg_pkg::N_REGIONS],
  input  logic                     rx_meta_out_ready [tcp_cfg_pkg::N_REGIONS],
  output tcp_rx_pkg::tcp_rx_meta_t rx_meta_out       [tcp_cfg_pkg::N_REGIONS],
  // Payload back to the regions
  input  logic                     axis_rx_in_valid,
  output logic                     axis_rx_in_ready,
  input  tcp_rx_pkg::axis_beat_t   axis_rx_in,
  output logic                     axis_rx_out_valid [tcp_cfg_pkg::N_REGIONS],
  input  logic                     axis_rx_out_ready [tcp_cfg_pkg::N_REGIONS],
  output tcp_rx_pkg::axis_beat_t   axis_rx_out       [tcp_cfg_pkg::N_REGIONS]
);

  // Port names match one to one
  tcp_rx_arbiter inst_rx_arbiter (.*);

endmodule

`default_nettype wire

// ==== bench/tcp_rx_tb.sv ====
/*
  Directed testbench for the receive region arbiter
  Clock, reset, queue-driven stream drivers and output monitors
  Tests for reset, single request, round robin, interleaving,
  back-pressure and the outstanding limit
  Cycle-count timeout
*/
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_tb;

  logic aclk = 1'b0;
  logic aresetn;
  logic                     rd_pkg_in_valid [tcp_cfg_pkg::N_REGIONS] = '{default: 1'b0};
  logic                     rd_pkg_in_ready [tcp_cfg_pkg::N_REGIONS];
  tcp_rx_pkg::tcp_rd_pkg_t  rd_pkg_in [tcp_cfg_pkg::N_REGIONS] = '{default: '0};
  logic                     rd_pkg_out_valid;
  logic                     rd_pkg_out_ready;
  tcp_rx_pkg::tcp_rd_pkg_t  rd_pkg_out;
  logic                     rx_meta_in_valid = 1'b0;
  logic                     rx_meta_in_ready;
  tcp_rx_pkg::tcp_rx_meta_t rx_meta_in = '0;
  logic                     rx_meta_out_valid [tcp_cfg_pkg::N_REGIONS];
  logic                     rx_meta_out_ready [tcp_cfg_pkg::N_REGIONS];
  tcp_rx_pkg::tcp_rx_meta_t rx_meta_out [tcp_cfg_pkg::N_REGIONS];
  logic                     axis_rx_in_valid = 1'b0;
  logic                     axis_rx_in_ready;
  tcp_rx_pkg::axis_beat_t   axis_rx_in = '0;
  logic                     axis_rx_out_valid [tcp_cfg_pkg::N_REGIONS];
  logic                     axis_rx_out_ready [tcp_cfg_pkg::N_REGIONS];
  tcp_rx_pkg::axis_beat_t   axis_rx_out [tcp_cfg_pkg::N_REGIONS];

  // Stimulus queues with fronts presented on the inputs
  tcp_rx_pkg::tcp_rd_pkg_t  req_q [tcp_cfg_pkg::N_REGIONS][$];
  tcp_rx_pkg::tcp_rx_meta_t meta_in_q [$];
  tcp_rx_pkg::axis_beat_t   beat_in_q [$];
  // Grants seen on rd_pkg_out in order
  tcp_rx_pkg::tcp_rd_pkg_t  grant_log [$];
  // Scoreboards per region
  tcp_rx_pkg::tcp_rx_meta_t exp_meta_q [tcp_cfg_pkg::N_REGIONS][$];
  tcp_rx_pkg::axis_beat_t   exp_beat_q [tcp_cfg_pkg::N_REGIONS][$];

  logic req_taken [tcp_cfg_pkg::N_REGIONS] = '{default: 1'b0};
  logic meta_taken = 1'b0;
  logic beat_taken = 1'b0;
  int   beats_seen [tcp_cfg_pkg::N_REGIONS] = '{default: 0};
  int   beats_accepted = 0;
  int   n_checks = 0;
  int   n_errors = 0;
  int   cycle_count = 0;
  logic [tcp_cfg_pkg::TCP_SID_BITS-tcp_cfg_pkg::N_REGIONS_BITS-1:0] serial = '0;

  tcp_rx_top DUT (.*);

  initial begin
    forever #5 aclk = ~aclk;
  end

  // Limit well above the few hundred cycles of the longest test
  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count >= 20000) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // --------------------
  // Checks
  task automatic expect_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic expect_beat(input string what, input tcp_rx_pkg::axis_beat_t got,
                             input tcp_rx_pkg::axis_beat_t exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Error at %0t: %s beat differs from the one sent", $time, what);
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    n_checks++;
    assert (cond) else begin
      n_errors++;
      $display("%s (at %0t)", msg, $time);
    end
  endtask

  function automatic int sid_region(input logic [tcp_cfg_pkg::TCP_SID_BITS-1:0] sid);
    return int'(sid[tcp_cfg_pkg::TCP_SID_BITS-1 -: tcp_cfg_pkg::N_REGIONS_BITS]);
  endfunction

  // --------------------
  // Drivers update 1 ns after the rising edge
  always @(posedge aclk) begin
    #1;
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin
      if (req_taken[i]) void'(req_q[i].pop_front());
      rd_pkg_in_valid[i] = (req_q[i].size() != 0);
      if (req_q[i].size() != 0) rd_pkg_in[i] = req_q[i][0];
    end
    if (meta_taken) void'(meta_in_q.pop_front());
    rx_meta_in_valid = (meta_in_q.size() != 0);
    if (meta_in_q.size() != 0) rx_meta_in = meta_in_q[0];
    if (beat_taken) void'(beat_in_q.pop_front());
    axis_rx_in_valid = (beat_in_q.size() != 0);
    if (beat_in_q.size() != 0) axis_rx_in = beat_in_q[0];
  end

  // Monitors sample mid-cycle before the transferring edge
  always @(negedge aclk) begin
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin
      req_taken[i] = rd_pkg_in_valid[i] && rd_pkg_in_ready[i];
      if (rx_meta_out_valid[i] && rx_meta_out_ready[i]) begin
        expect_true(exp_meta_q[i].size() != 0,
                    $sformatf("Region %0d received metadata it never asked for", i));
        if (exp_meta_q[i].size() != 0)
          expect_word($sformatf("rx_meta_out[%0d]", i), rx_meta_out[i],
                      exp_meta_q[i].pop_front());
      end
      if (axis_rx_out_valid[i] && axis_rx_out_ready[i]) begin
        beats_seen[i]++;
        expect_true(exp_beat_q[i].size() != 0,
                    $sformatf("Region %0d received a beat that was never sent to it", i));
        if (exp_beat_q[i].size() != 0)
          expect_beat($sformatf("axis_rx_out[%0d]", i), axis_rx_out[i],
                      exp_beat_q[i].pop_front());
      end
    end
    meta_taken = rx_meta_in_valid && rx_meta_in_ready;
    beat_taken = axis_rx_in_valid && axis_rx_in_ready;
    if (beat_taken) beats_accepted++;
    if (rd_pkg_out_valid && rd_pkg_out_ready) grant_log.push_back(rd_pkg_out);
  end

  // --------------------
  // Stimulus helpers for use at a rising edge
  task automatic queue_request(input int region, input int len,
                               output tcp_rx_pkg::tcp_rd_pkg_t req);
    // Region rides in the top sid bits
    req.sid = {region[tcp_cfg_pkg::N_REGIONS_BITS-1:0], serial};
    req.len = len[tcp_cfg_pkg::TCP_LEN_BITS-1:0];
    serial++;
    req_q[region].push_back(req);
  endtask

  task automatic queue_meta(input tcp_rx_pkg::tcp_rd_pkg_t req);
    tcp_rx_pkg::tcp_rx_meta_t meta;
    meta.sid = req.sid;
    meta.len = req.len;
    meta_in_q.push_back(meta);
    exp_meta_q[sid_region(req.sid)].push_back(meta);
  endtask

  // ceil(len / 64) random beats for one package
  task automatic queue_payload(input tcp_rx_pkg::tcp_rd_pkg_t req);
    tcp_rx_pkg::axis_beat_t beat;
    int n_beats;
    n_beats = (int'(req.len) + 63) >> tcp_cfg_pkg::BEAT_LOG_BITS;
    for (int k = 0; k < n_beats; k++) begin
      for (int w = 0; w < tcp_cfg_pkg::AXI_NET_BITS / 32; w++) beat.data[w*32 +: 32] = $urandom;
      beat.keep = {$urandom, $urandom};
      beat.last = (k == n_beats - 1);
      beat_in_q.push_back(beat);
      exp_beat_q[sid_region(req.sid)].push_back(beat);
    end
  endtask

  // Answer grants in grant order as they appear
  task automatic return_traffic(input int n);
    tcp_rx_pkg::tcp_rd_pkg_t req;
    for (int k = 0; k < n; k++) begin
      @(posedge aclk);
      while (grant_log.size() == 0) @(posedge aclk);
      req = grant_log.pop_front();
      queue_meta(req);
      queue_payload(req);
    end
  endtask

  task automatic wait_grants(input int n);
    @(posedge aclk);
    while (grant_log.size() < n) @(posedge aclk);
  endtask

  function automatic logic traffic_idle();
    logic idle;
    idle = (meta_in_q.size() == 0) && (beat_in_q.size() == 0);
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin
      idle = idle && (req_q[i].size() == 0) && (exp_meta_q[i].size() == 0)
             && (exp_beat_q[i].size() == 0);
    end
    return idle;
  endfunction

  // A few idle cycles catch duplicates
  task automatic wait_drained();
    do @(posedge aclk); while (!traffic_idle());
    repeat (4) @(posedge aclk);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (n_errors == errors_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, n_errors - errors_before);
  endtask

  // --------------------
  // Tests
  task automatic check_valids_low(input string when);
    expect_true(!rd_pkg_out_valid, {"rd_pkg_out valid is high ", when});
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin
      expect_true(!rx_meta_out_valid[i], $sformatf("rx_meta_out[%0d] valid high %s", i, when));
      expect_true(!axis_rx_out_valid[i], $sformatf("axis_rx_out[%0d] valid high %s", i, when));
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = n_errors;
    repeat (3) begin
      @(negedge aclk);
      check_valids_low("during reset");
    end
    @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(negedge aclk);
    check_valids_low("in the first cycle after reset");
    report_test("reset", e0);
  endtask

  task automatic test_single();
    tcp_rx_pkg::tcp_rd_pkg_t req;
    int seen0 [tcp_cfg_pkg::N_REGIONS];
    int e0;
    e0 = n_errors;
    seen0 = beats_seen;
    @(posedge aclk);
    queue_request(2, 150, req);
    wait_grants(1);
    expect_word("rd_pkg_out", grant_log[0], req);
    return_traffic(1);
    wait_drained();
    // 150 bytes is three beats
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++)
      expect_word($sformatf("beats to region %0d", i), beats_seen[i] - seen0[i], (i == 2) ? 3 : 0);
    report_test("single request", e0);
  endtask

  task automatic test_round_robin();
    tcp_rx_pkg::tcp_rd_pkg_t req;
    int order [7] = '{0, 1, 2, 3, 1, 3, 1};
    int e0;
    e0 = n_errors;
    @(posedge aclk);
    for (int r = 0; r < tcp_cfg_pkg::N_REGIONS; r++) queue_request(r, 64 * (r + 1), req);
    wait_grants(4);
    for (int k = 0; k < 4; k++)
      expect_word($sformatf("grant %0d region", k), sid_region(grant_log[k].sid), order[k]);
    return_traffic(4);
    wait_drained();
    // Pointer at 2 after region 1 lets region 3 win over 1
    queue_request(1, 64, req);
    wait_grants(1);
    queue_request(1, 64, req);
    queue_request(3, 64, req);
    wait_grants(3);
    for (int k = 4; k < 7; k++)
      expect_word($sformatf("grant %0d region", k), sid_region(grant_log[k-4].sid), order[k]);
    return_traffic(3);
    wait_drained();
    report_test("round robin", e0);
  endtask

  task automatic test_interleaved();
    tcp_rx_pkg::tcp_rd_pkg_t req;
    int seen0 [tcp_cfg_pkg::N_REGIONS];
    int exp_total [tcp_cfg_pkg::N_REGIONS] = '{default: 0};
    int e0;
    e0 = n_errors;
    seen0 = beats_seen;
    @(posedge aclk);
    for (int k = 0; k < 12; k++) begin
      queue_request(int'($urandom_range(3, 0)), int'($urandom_range(300, 1)), req);
      exp_total[sid_region(req.sid)] += (int'(req.len) + 63) / 64;
    end
    return_traffic(12);
    wait_drained();
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++)
      expect_word($sformatf("beats to region %0d", i), beats_seen[i] - seen0[i], exp_total[i]);
    report_test("interleaved traffic", e0);
  endtask

  task automatic test_backpressure();
    tcp_rx_pkg::tcp_rd_pkg_t req;
    int seen0 [tcp_cfg_pkg::N_REGIONS];
    int acc0;
    int stall;
    int e0;
    e0 = n_errors;
    @(posedge aclk);
    #1;
    axis_rx_out_ready[1] = 1'b0;
    @(posedge aclk);
    seen0 = beats_seen;
    acc0 = beats_accepted;
    // 20 beats overflow the region FIFO
    queue_request(1, 20 * 64, req);
    wait_grants(1);
    queue_request(3, 128, req);
    return_traffic(2);
    stall = 0;
    while (stall < 8) begin
      @(negedge aclk);
      if (axis_rx_in_valid && !axis_rx_in_ready) stall++;
      else stall = 0;
    end
    @(posedge aclk);
    expect_true(beats_accepted - acc0 >= tcp_cfg_pkg::REGION_FIFO_DEPTH,
                "Input stalled before the region FIFO was full");
    expect_true(beats_accepted - acc0 < 20, "All beats were accepted despite the full FIFO");
    expect_word("beats to region 3 while stalled", beats_seen[3] - seen0[3], 0);
    #1;
    axis_rx_out_ready[1] = 1'b1;
    wait_drained();
    expect_word("beats to region 1", beats_seen[1] - seen0[1], 20);
    expect_word("beats to region 3", beats_seen[3] - seen0[3], 2);
    report_test("back-pressure", e0);
  endtask

  task automatic test_outstanding();
    tcp_rx_pkg::tcp_rd_pkg_t req;
    tcp_rx_pkg::tcp_rd_pkg_t first;
    int e0;
    e0 = n_errors;
    @(posedge aclk);
    for (int k = 0; k < 10; k++) queue_request(0, 64, req);
    wait_grants(tcp_cfg_pkg::N_OUTSTANDING);
    repeat (10) begin
      @(negedge aclk);
      for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++)
        expect_true(!rd_pkg_in_ready[i], $sformatf("rd_pkg_in_ready[%0d] high with full queues", i));
    end
    @(posedge aclk);
    expect_word("requests accepted", grant_log.size(), tcp_cfg_pkg::N_OUTSTANDING);
    // One metadata transfer frees exactly one slot
    first = grant_log.pop_front();
    queue_meta(first);
    wait_grants(tcp_cfg_pkg::N_OUTSTANDING);
    repeat (10) @(posedge aclk);
    expect_word("requests after one metadata", grant_log.size(), tcp_cfg_pkg::N_OUTSTANDING);
    queue_payload(first);
    return_traffic(9);
    wait_drained();
    report_test("outstanding limit", e0);
  endtask

  // --------------------
  initial begin
    void'($urandom(32'hb6a4_d64c));
    aresetn = 1'b0;
    rd_pkg_out_ready = 1'b1;
    for (int i = 0; i < tcp_cfg_pkg::N_REGIONS; i++) begin
      rx_meta_out_ready[i] = 1'b1;
      axis_rx_out_ready[i] = 1'b1;
    end
    test_reset();
    // Round robin needs the pointer fresh from reset
    test_round_robin();
    test_single();
    test_interleaved();
    test_backpressure();
    test_outstanding();
    $display("checks passed %0d, failed %0d", n_checks - n_errors, n_errors);
    if (n_errors == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tcp_rx.f ====
verilog/tcp_cfg_pkg.sv
verilog/tcp_rx_pkg.sv
verilog/meta_arbiter.sv
verilog/seq_queue.sv
verilog/axis_region_fifo.sv
verilog/tcp_rx_arbiter.sv
verilog/tcp_rx_top.sv
bench/tcp_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the receive arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tcp_rx_tb \
  -f tcp_rx.f \
  -o sim_tcp_rx

out="$(./obj_dir/sim_tcp_rx)"
echo "$out"

if grep -q "STATUS: PASS" <<< "$out"; then
  exit 0
fi
exit 1
